/* design/fc_pkg.sv */
// Shared widths, addresses and types for the event and interrupt front end, imported by each block
package fc_pkg;

  // Direct interrupt lines
  localparam int unsigned NB_LINES  = 32;
  localparam int unsigned LINE_ID_W = 5;

  // Peripheral event queue
  localparam int unsigned EVT_ID_W   = 8;
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned FIFO_PIN   = 11;

  // Configuration port map
  localparam int unsigned CFG_ADDR_W = 2;
  localparam logic [CFG_ADDR_W-1:0] CFG_MASK_ADDR = 2'd0;
  localparam logic [CFG_ADDR_W-1:0] CFG_PEND_ADDR = 2'd1;

  typedef logic [NB_LINES-1:0]  line_vec_t;
  typedef logic [LINE_ID_W-1:0] line_id_t;
  typedef logic [EVT_ID_W-1:0]  evt_id_t;

  // Configuration port handshake states
  typedef enum logic {
    CFG_IDLE,
    CFG_ACK
  } cfg_state_t;

  // Core interrupt handshake states
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_REQ,
    ARB_WAIT
  } arb_state_t;

endpackage

/* design/fc_event_fifo.sv */
// Circular queue of peripheral event ids, filled over valid/full-not and drained by the arbiter
`timescale 1ns/1ps

module fc_event_fifo import fc_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    push_valid_i,
  input  evt_id_t push_data_i,
  output logic    fulln_o,
  output logic    nempty_o,
  output evt_id_t head_o,
  input  logic    pop_i
);

  evt_id_t                mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0]  wr_ptr_q;
  logic [FIFO_PTR_W-1:0]  rd_ptr_q;
  logic [FIFO_CNT_W-1:0]  count_q;
  logic                   push;
  logic                   pop;

  // Status straight from the entry count
  assign fulln_o  = (count_q != FIFO_CNT_W'(FIFO_DEPTH));
  assign nempty_o = (count_q != '0);
  assign head_o   = mem_q[rd_ptr_q];

  // Source must hold its push while fulln_o is low
  assign push = push_valid_i & fulln_o;
  assign pop  = pop_i & nempty_o;

  //****************************************
  // Pointers and count
  //****************************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        // Push with pop, or neither, leaves the count
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* design/fc_irq_lines.sv */
// Pending and mask registers of the 32 direct event lines, with their four-phase config port
`timescale 1ns/1ps

module fc_irq_lines import fc_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  line_vec_t             events_i,
  // Configuration port
  input  logic                  cfg_req_i,
  input  logic                  cfg_we_i,
  input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
  input  line_vec_t             cfg_wdata_i,
  output logic                  cfg_ack_o,
  output line_vec_t             cfg_rdata_o,
  // Claim from the arbiter
  input  logic                  claim_i,
  input  line_id_t              claim_id_i,
  output line_vec_t             pend_o
);

  line_vec_t  pend_q;
  line_vec_t  mask_q;
  line_vec_t  claim_clr;
  cfg_state_t cfg_state_q;
  logic       cfg_start;
  logic       mask_wr;

  //****************************************
  // Pending lines
  //****************************************

  // One-hot clear of the claimed line
  always_comb begin
    claim_clr = '0;
    if (claim_i) begin
      claim_clr[claim_id_i] = 1'b1;
    end
  end

  // A new event beats a claim on the same bit
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_q <= '0;
    end else begin
      pend_q <= (pend_q & ~claim_clr) | events_i;
    end
  end

  assign pend_o = pend_q & mask_q;

  //****************************************
  // Configuration handshake
  //****************************************

  // Access happens once, on the edge that raises ack
  assign cfg_start = (cfg_state_q == CFG_IDLE) && cfg_req_i;
  assign mask_wr   = cfg_start && cfg_we_i && (cfg_addr_i == CFG_MASK_ADDR);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_state_q <= CFG_IDLE;
    end else begin
      case (cfg_state_q)
        CFG_IDLE: begin
          if (cfg_req_i) begin
            cfg_state_q <= CFG_ACK;
          end
        end
        CFG_ACK: begin
          // Hold ack until the master lets go of req
          if (!cfg_req_i) begin
            cfg_state_q <= CFG_IDLE;
          end
        end
        default: cfg_state_q <= CFG_IDLE;
      endcase
    end
  end

  // Zero mask after reset blocks every line
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mask_q <= '0;
    end else if (mask_wr) begin
      mask_q <= cfg_wdata_i;
    end
  end

  assign cfg_ack_o = (cfg_state_q == CFG_ACK);

  // Read data valid while ack is up
  // Pending reads back raw without the mask
  always_comb begin
    cfg_rdata_o = '0;
    if (cfg_ack_o) begin
      case (cfg_addr_i)
        CFG_MASK_ADDR: cfg_rdata_o = mask_q;
        CFG_PEND_ADDR: cfg_rdata_o = pend_q;
        default:       cfg_rdata_o = '0;
      endcase
    end
  end

endmodule

/* design/fc_irq_arbiter.sv */
// Picks the lowest pending line or queued event and drives the core interrupt req/ack handshake
`timescale 1ns/1ps

module fc_irq_arbiter import fc_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  line_vec_t line_pend_i,
  // Event queue side
  input  logic      fifo_nempty_i,
  input  evt_id_t   fifo_head_i,
  output logic      fifo_pop_o,
  // Claim back to the lines block
  output logic      claim_o,
  output line_id_t  claim_id_o,
  // Core interrupt
  output logic      irq_req_o,
  output line_id_t  irq_id_o,
  output evt_id_t   irq_evt_o,
  input  logic      irq_ack_i
);

  line_vec_t  all_pend;
  line_id_t   sel_id;
  logic       sel_fifo;
  arb_state_t state_q;
  line_id_t   id_q;
  evt_id_t    evt_q;
  logic       fifo_sel_q;
  logic       claim_q;
  logic       pop_q;

  //****************************************
  // Selection
  //****************************************

  // Queue shows up as one more source on FIFO_PIN
  always_comb begin
    all_pend = line_pend_i;
    if (fifo_nempty_i) begin
      all_pend[FIFO_PIN] = 1'b1;
    end
  end

  // Scan from the top so the lowest set index writes sel_id last
  always_comb begin
    sel_id = '0;
    for (int i = NB_LINES - 1; i >= 0; i--) begin
      if (all_pend[i]) begin
        sel_id = line_id_t'(i);
      end
    end
  end

  assign sel_fifo = (sel_id == line_id_t'(FIFO_PIN)) && fifo_nempty_i;

  //****************************************
  // Handshake FSM
  //****************************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= ARB_IDLE;
      fifo_sel_q <= 1'b0;
      claim_q    <= 1'b0;
      pop_q      <= 1'b0;
    end else begin
      claim_q <= 1'b0;
      pop_q   <= 1'b0;
      case (state_q)
        ARB_IDLE: begin
          if (|all_pend) begin
            state_q    <= ARB_REQ;
            fifo_sel_q <= sel_fifo;
          end
        end
        ARB_REQ: begin
          // Retire in the cycle after the ack edge
          if (irq_ack_i) begin
            state_q <= ARB_WAIT;
            claim_q <= 1'b1;
            pop_q   <= fifo_sel_q;
          end
        end
        ARB_WAIT: begin
          if (!irq_ack_i) begin
            state_q <= ARB_IDLE;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  // Id and queue head held stable for the whole request
  always_ff @(posedge clk_i) begin
    if ((state_q == ARB_IDLE) && (|all_pend)) begin
      id_q  <= sel_id;
      evt_q <= sel_fifo ? fifo_head_i : '0;
    end
  end

  assign irq_req_o  = (state_q == ARB_REQ);
  assign irq_id_o   = id_q;
  assign irq_evt_o  = evt_q;
  assign claim_o    = claim_q;
  assign claim_id_o = id_q;
  assign fifo_pop_o = pop_q;

endmodule

/* design/fc_subsystem.sv */
// Top level of the event and interrupt front end, wiring the queue, the lines block and the arbiter
`timescale 1ns/1ps

module fc_subsystem import fc_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Direct events, one per line
  input  line_vec_t             events_i,
  // Peripheral event queue
  input  logic                  event_fifo_valid_i,
  input  evt_id_t               event_fifo_data_i,
  output logic                  event_fifo_fulln_o,
  // Configuration port
  input  logic                  cfg_req_i,
  input  logic                  cfg_we_i,
  input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
  input  line_vec_t             cfg_wdata_i,
  output logic                  cfg_ack_o,
  output line_vec_t             cfg_rdata_o,
  // Core interrupt
  output logic                  irq_req_o,
  output line_id_t              irq_id_o,
  output evt_id_t               irq_evt_o,
  input  logic                  irq_ack_i
);

  line_vec_t line_pend;
  logic      claim;
  line_id_t  claim_id;
  logic      fifo_nempty;
  evt_id_t   fifo_head;
  logic      fifo_pop;

  //****************************************
  // Event sources
  //****************************************
  fc_event_fifo u_event_fifo (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_valid_i (event_fifo_valid_i),
    .push_data_i  (event_fifo_data_i),
    .fulln_o      (event_fifo_fulln_o),
    .nempty_o     (fifo_nempty),
    .head_o       (fifo_head),
    .pop_i        (fifo_pop)
  );

  fc_irq_lines u_irq_lines (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .events_i    (events_i),
    .cfg_req_i   (cfg_req_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_ack_o   (cfg_ack_o),
    .cfg_rdata_o (cfg_rdata_o),
    .claim_i     (claim),
    .claim_id_i  (claim_id),
    .pend_o      (line_pend)
  );

  // Arbitration toward the core
  fc_irq_arbiter u_irq_arbiter (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .line_pend_i   (line_pend),
    .fifo_nempty_i (fifo_nempty),
    .fifo_head_i   (fifo_head),
    .fifo_pop_o    (fifo_pop),
    .claim_o       (claim),
    .claim_id_o    (claim_id),
    .irq_req_o     (irq_req_o),
    .irq_id_o      (irq_id_o),
    .irq_evt_o     (irq_evt_o),
    .irq_ack_i     (irq_ack_i)
  );

endmodule

/* dv/tb_fc_subsystem.sv */
// Table-driven testbench for fc_subsystem with a reference model of mask, pending and queue
`timescale 1ns/1ps

module tb_fc_subsystem import fc_pkg::*; ();

  localparam int TIMEOUT = 50;

  typedef enum int {OP_WR, OP_RD, OP_PULSE, OP_PUSH, OP_SERVICE, OP_QUIET} op_e;

  logic                  clk;
  logic                  reset;
  line_vec_t             events;
  logic                  fifo_valid;
  evt_id_t               fifo_data;
  logic                  fifo_fulln;
  logic                  cfg_req;
  logic                  cfg_we;
  logic [CFG_ADDR_W-1:0] cfg_addr;
  line_vec_t             cfg_wdata;
  logic                  cfg_ack;
  line_vec_t             cfg_rdata;
  logic                  irq_req;
  line_id_t              irq_id;
  evt_id_t               irq_evt;
  logic                  irq_ack;

  // Step table held as one queue per column
  op_e       step_op [$];
  line_vec_t step_a  [$];
  line_vec_t step_d  [$];

  // Reference model
  line_vec_t mdl_mask;
  line_vec_t mdl_pend;
  evt_id_t   mdl_q [$];
  logic      mdl_busy;
  line_id_t  mdl_id;
  evt_id_t   mdl_evt;
  logic      mdl_pop;

  int     err_cnt;
  int     chk_cnt;
  integer seed;

  fc_subsystem u_dut (
    .clk_i              (clk),
    .reset_i            (reset),
    .events_i           (events),
    .event_fifo_valid_i (fifo_valid),
    .event_fifo_data_i  (fifo_data),
    .event_fifo_fulln_o (fifo_fulln),
    .cfg_req_i          (cfg_req),
    .cfg_we_i           (cfg_we),
    .cfg_addr_i         (cfg_addr),
    .cfg_wdata_i        (cfg_wdata),
    .cfg_ack_o          (cfg_ack),
    .cfg_rdata_o        (cfg_rdata),
    .irq_req_o          (irq_req),
    .irq_id_o           (irq_id),
    .irq_evt_o          (irq_evt),
    .irq_ack_i          (irq_ack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //****************************************
  // Reference model
  //****************************************

  // Arbiter latches the lowest source only while idle
  task automatic model_select();
    line_vec_t cand;
    cand = mdl_pend & mdl_mask;
    if (mdl_q.size() > 0) begin
      cand[FIFO_PIN] = 1'b1;
    end
    if (!mdl_busy && (cand != '0)) begin
      for (int i = 0; i < NB_LINES; i++) begin
        if (cand[i]) begin
          mdl_id = line_id_t'(i);
          break;
        end
      end
      mdl_pop  = (mdl_id == line_id_t'(FIFO_PIN)) && (mdl_q.size() > 0);
      mdl_evt  = mdl_pop ? mdl_q[0] : '0;
      mdl_busy = 1'b1;
    end
  endtask

  task automatic model_retire();
    mdl_pend[mdl_id] = 1'b0;
    if (mdl_pop) begin
      void'(mdl_q.pop_front());
    end
    mdl_busy = 1'b0;
    model_select();
  endtask

  //****************************************
  // Bus drivers
  //****************************************
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic cfg_access(input logic we, input logic [CFG_ADDR_W-1:0] addr,
                            input line_vec_t wdata, output line_vec_t rdata);
    int n;
    cfg_req   = 1'b1;
    cfg_we    = we;
    cfg_addr  = addr;
    cfg_wdata = wdata;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (!cfg_ack && (n < TIMEOUT));
    if (!cfg_ack) begin
      err_cnt++;
      $display("Config port never raised ack at %0t", $time);
    end
    rdata   = cfg_rdata;
    cfg_req = 1'b0;
    cfg_we  = 1'b0;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (cfg_ack && (n < TIMEOUT));
    if (cfg_ack) begin
      err_cnt++;
      $display("Config ack stayed high after req was released at %0t", $time);
    end
    if (we && (addr == CFG_MASK_ADDR)) begin
      mdl_mask = wdata;
    end
    model_select();
  endtask

  task automatic pulse_events(input line_vec_t vec);
    events = vec;
    next_cycle();
    events = '0;
    mdl_pend = mdl_pend | vec;
    model_select();
  endtask

  // Offered for one cycle only; a full queue must refuse it
  task automatic push_event(input evt_id_t data);
    logic exp_fulln;
    exp_fulln = (mdl_q.size() < FIFO_DEPTH);
    chk_cnt++;
    if (fifo_fulln !== exp_fulln) begin
      err_cnt++;
      $display("FAIL %0t event_fifo_fulln_o got %0b expected %0b", $time, fifo_fulln, exp_fulln);
    end
    fifo_valid = 1'b1;
    fifo_data  = data;
    next_cycle();
    fifo_valid = 1'b0;
    if (exp_fulln) begin
      mdl_q.push_back(data);
      model_select();
    end
  endtask

  // Acts as the core on the four-phase interrupt handshake
  task automatic service_irq(input line_id_t exp_id, input evt_id_t exp_evt);
    int n;
    n = 0;
    while (!irq_req && (n < TIMEOUT)) begin
      next_cycle();
      n++;
    end
    if (!irq_req) begin
      err_cnt++;
      $display("No interrupt request at %0t, line %0d was due", $time, exp_id);
    end else begin
      chk_cnt += 2;
      if (irq_id !== exp_id) begin
        err_cnt++;
        $display("FAIL %0t irq_id_o got %0d expected %0d", $time, irq_id, exp_id);
      end
      if (irq_evt !== exp_evt) begin
        err_cnt++;
        $display("FAIL %0t irq_evt_o got 0x%0h expected 0x%0h", $time, irq_evt, exp_evt);
      end
      irq_ack = 1'b1;
      n = 0;
      do begin
        next_cycle();
        n++;
      end while (irq_req && (n < TIMEOUT));
      if (irq_req) begin
        err_cnt++;
        $display("Interrupt request stayed high after ack at %0t", $time);
      end
      irq_ack = 1'b0;
      // Leave room for the claim to settle
      next_cycle();
    end
    model_retire();
  endtask

  task automatic add_step(input op_e op, input line_vec_t a, input line_vec_t d);
    step_op.push_back(op);
    step_a.push_back(a);
    step_d.push_back(d);
  endtask

  //****************************************
  // Directed steps
  //****************************************
  task automatic build_table();
    // Config readback and raw pending of masked lines
    add_step(OP_RD,      32'(CFG_MASK_ADDR), 32'h0000_0000);
    add_step(OP_WR,      32'(CFG_MASK_ADDR), 32'h0000_00F0);
    add_step(OP_RD,      32'(CFG_MASK_ADDR), 32'h0000_00F0);
    add_step(OP_WR,      32'(CFG_MASK_ADDR), 32'h0000_0000);
    add_step(OP_PULSE,   32'h0,              32'h0000_0124);
    add_step(OP_QUIET,   32'd8,              32'h0);
    add_step(OP_RD,      32'(CFG_PEND_ADDR), 32'h0000_0124);
    add_step(OP_WR,      32'(CFG_PEND_ADDR), 32'hFFFF_FFFF);
    add_step(OP_RD,      32'(CFG_PEND_ADDR), 32'h0000_0124);
    // Open the mask, lowest line first
    add_step(OP_WR,      32'(CFG_MASK_ADDR), 32'hFFFF_FFFF);
    add_step(OP_SERVICE, 32'd2,              32'h0);
    add_step(OP_SERVICE, 32'd5,              32'h0);
    add_step(OP_SERVICE, 32'd8,              32'h0);
    add_step(OP_RD,      32'(CFG_PEND_ADDR), 32'h0000_0000);
    add_step(OP_PULSE,   32'h0,              32'h8001_0010);
    add_step(OP_SERVICE, 32'd4,              32'h0);
    add_step(OP_SERVICE, 32'd16,             32'h0);
    add_step(OP_SERVICE, 32'd31,             32'h0);
    // Queue fill, overflow push, then drain in order
    add_step(OP_PUSH,    32'h0,              32'h3A);
    add_step(OP_PUSH,    32'h0,              32'h5C);
    add_step(OP_PUSH,    32'h0,              32'h71);
    add_step(OP_PUSH,    32'h0,              32'h9E);
    add_step(OP_PUSH,    32'h0,              32'hEE);
    add_step(OP_SERVICE, 32'(FIFO_PIN),      32'h3A);
    add_step(OP_SERVICE, 32'(FIFO_PIN),      32'h5C);
    add_step(OP_SERVICE, 32'(FIFO_PIN),      32'h71);
    add_step(OP_SERVICE, 32'(FIFO_PIN),      32'h9E);
    add_step(OP_QUIET,   32'd4,              32'h0);
    // Line 11 and a queue entry retire together
    add_step(OP_PUSH,    32'h0,              32'h42);
    add_step(OP_PULSE,   32'h0,              32'h0000_0801);
    add_step(OP_SERVICE, 32'(FIFO_PIN),      32'h42);
    add_step(OP_SERVICE, 32'd0,              32'h0);
    add_step(OP_RD,      32'(CFG_PEND_ADDR), 32'h0000_0000);
  endtask

  initial begin
    line_vec_t rd;
    line_vec_t rnd;
    int        n_push;
    int        guard;
    seed       = 66485;
    err_cnt    = 0;
    chk_cnt    = 0;
    reset      = 1'b1;
    events     = '0;
    fifo_valid = 1'b0;
    fifo_data  = '0;
    cfg_req    = 1'b0;
    cfg_we     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    irq_ack    = 1'b0;
    mdl_mask   = '0;
    mdl_pend   = '0;
    mdl_busy   = 1'b0;
    mdl_id     = '0;
    mdl_evt    = '0;
    mdl_pop    = 1'b0;
    build_table();
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    for (int s = 0; s < step_op.size(); s++) begin
      case (step_op[s])
        OP_WR: cfg_access(1'b1, step_a[s][CFG_ADDR_W-1:0], step_d[s], rd);
        OP_RD: begin
          cfg_access(1'b0, step_a[s][CFG_ADDR_W-1:0], '0, rd);
          chk_cnt++;
          if (rd !== step_d[s]) begin
            err_cnt++;
            $display("FAIL %0t cfg_rdata_o got 0x%0h expected 0x%0h", $time, rd, step_d[s]);
          end
        end
        OP_PULSE: pulse_events(step_d[s]);
        OP_PUSH:  push_event(evt_id_t'(step_d[s]));
        OP_SERVICE: begin
          if (!mdl_busy || (step_a[s] != 32'(mdl_id)) || (step_d[s] != 32'(mdl_evt))) begin
            err_cnt++;
            $display("Step %0d: table and reference model disagree on the next interrupt", s);
          end
          service_irq(line_id_t'(step_a[s]), evt_id_t'(step_d[s]));
        end
        default: begin
          for (int c = 0; c < int'(step_a[s]); c++) begin
            chk_cnt++;
            if (irq_req !== 1'b0) begin
              err_cnt++;
              $display("FAIL %0t irq_req_o got %0b expected 0", $time, irq_req);
            end
            next_cycle();
          end
        end
      endcase
    end

    //****************************************
    // Random phase
    //****************************************
    for (int r = 0; r < 16; r++) begin
      rnd = $random(seed);
      cfg_access(1'b1, CFG_MASK_ADDR, rnd, rd);
      rnd = $random(seed) & $random(seed);
      pulse_events(rnd);
      n_push = $random(seed) & 3;
      for (int p = 0; p < n_push; p++) begin
        push_event(evt_id_t'($random(seed)));
      end
      guard = 0;
      while (mdl_busy && (guard < 80)) begin
        service_irq(mdl_id, mdl_evt);
        guard++;
      end
    end
    cfg_access(1'b0, CFG_PEND_ADDR, '0, rd);
    chk_cnt++;
    if (rd !== mdl_pend) begin
      err_cnt++;
      $display("FAIL %0t cfg_rdata_o got 0x%0h expected 0x%0h", $time, rd, mdl_pend);
    end

    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
design/fc_pkg.sv
design/fc_event_fifo.sv
design/fc_irq_lines.sv
design/fc_irq_arbiter.sv
design/fc_subsystem.sv
dv/tb_fc_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the fc_subsystem testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=tb_fc_subsystem
OBJ_DIR=obj_dir
BIN=sim_fc
BUILD_LOG=build.log
SIM_LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

# Compile and elaborate
verilator --binary --timing -j 0 \
  --top-module "$TOP" \
  -f vlog.f \
  -Mdir "$OBJ_DIR" \
  -o "$BIN" > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed with status $status"
  exit 1
fi

# Run the simulation
"./$OBJ_DIR/$BIN" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict from the log
if grep -q "tests failed" "$SIM_LOG"; then
  echo "Simulation reported failures"
  exit 1
fi
echo "Simulation finished clean"
exit 0
